/* all.f */
+incdir+.
audioPkg.sv
sfmRomReader.sv
pcmMixer.sv
sampleFifo.sv
i2sTx.sv
audioTxBlock.sv
sfmModel.sv
tbAudioTx_sva.sv
tbAudioTx.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the audio subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbAudioTx -f all.f -o simAudioTx
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/simAudioTx +verilator+error+limit+100 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Test completed successfully" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tbAudioTx.sv */
`timescale 1ns/1ps
`include "audio_macros.svh"

module tbAudioTx;

	localparam int CH = `AUDIO_CH_NUM;
	localparam int FRAME_LIMIT = 600;
	localparam int DONE_LIMIT = 20000;

	logic iSCLK;
	logic iSRST;
	logic [CH-1:0] chanEnable;
	logic [CH-1:0] chanLoop;
	logic [CH*`IDX_W-1:0] chanStartIdx;
	logic [CH*`IDX_W-1:0] chanEndIdx;
	logic [CH-1:0] sfmSck;
	logic [CH-1:0] sfmMosi;
	logic [CH-1:0] sfmCs;
	logic [CH-1:0] sfmMiso;
	logic [CH-1:0] chanDone;
	logic [CH-1:0] badCmd;
	logic i2sBclk;
	logic i2sLrclk;
	logic i2sSdata;
	logic underrun;
	logic [`IDX_W-1:0] s;

	audioTxBlock dut0 (.*);

	// One flash per channel
	for (genvar c = 0; c < CH; c++)
	begin : genFlash
		sfmModel #(.CH(c)) flash (
			.iSCLK(iSCLK),
			.sck(sfmSck[c]),
			.cs(sfmCs[c]),
			.mosi(sfmMosi[c]),
			.miso(sfmMiso[c]),
			.badCmd(badCmd[c])
		);
	end

	initial
	begin
		iSCLK = 1'b0;
		forever #5 iSCLK = ~iSCLK;
	end

	task automatic abortRun(string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1, "run stopped");
	endtask

	// Any checker or flash failure ends the run
	always @(posedge iSCLK)
	begin
		if (!iSRST && (dut0.chk0.anyFail || |badCmd))
			abortRun($sformatf("CHECK FAILED at %0t: assertion or flash command", $time));
	end

	task automatic setChannel(int c, logic lp, logic [15:0] st, logic [15:0] en);
		chanLoop[c] = lp;
		chanStartIdx[c*`IDX_W +: `IDX_W] = st;
		chanEndIdx[c*`IDX_W +: `IDX_W] = en;
	endtask

	// LRCLK rises once per frame
	task automatic waitFrames(int n);
		int cnt;
		logic lrQ;
		for (int k = 0; k < n; k++)
		begin
			cnt = 0;
			lrQ = i2sLrclk;
			while (!(i2sLrclk && !lrQ))
			begin
				lrQ = i2sLrclk;
				@(negedge iSCLK);
				cnt++;
				if (cnt > FRAME_LIMIT)
					abortRun("Timeout: no I2S frame started in time");
			end
		end
	endtask

	task automatic waitDone(int c);
		int cnt;
		cnt = 0;
		while (!chanDone[c])
		begin
			@(negedge iSCLK);
			cnt++;
			if (cnt > DONE_LIMIT)
				abortRun($sformatf("Timeout: channel %0d never finished", c));
		end
	endtask

	task automatic runMask(logic [CH-1:0] mask, int frames);
		@(negedge iSCLK);
		chanEnable = mask;
		waitFrames(frames);
		@(negedge iSCLK);
		chanEnable = '0;
	endtask

	initial
	begin
		void'($urandom(32'h1fb101b2));
		iSRST = 1'b1;
		chanEnable = '0;
		chanLoop = '0;
		chanStartIdx = '0;
		chanEndIdx = '0;
		repeat (16) @(negedge iSCLK);
		iSRST = 1'b0;
		waitFrames(2);

		// Single channel plays to its end and goes silent
		s = 16'($urandom % 4096);
		setChannel(0, 1'b0, s, s + 16'd24);
		@(negedge iSCLK);
		chanEnable = 3'b001;
		waitDone(0);
		waitFrames(16);
		@(negedge iSCLK);
		chanEnable = '0;

		// Short loop on ch0 plus ch1
		s = 16'($urandom % 4096);
		setChannel(0, 1'b1, s, s + 16'd5);
		s = 16'($urandom % 4096);
		setChannel(1, 1'b0, s, s + 16'd200);
		runMask(3'b011, 40);

		// All three
		s = 16'($urandom % 4096);
		setChannel(2, 1'b1, s, s + 16'd9);
		runMask(3'b111, 30);

		// Starts where every channel sits near +0x7000
		setChannel(0, 1'b1, 16'h0070, 16'h0073);
		setChannel(1, 1'b1, 16'h0060, 16'h0063);
		setChannel(2, 1'b1, 16'h0050, 16'h0053);
		runMask(3'b111, 30);

		// And near 0x9000, negative
		setChannel(0, 1'b1, 16'h0090, 16'h0093);
		setChannel(1, 1'b1, 16'h0080, 16'h0083);
		setChannel(2, 1'b1, 16'h0070, 16'h0073);
		runMask(3'b111, 30);

		// FIFO drains, then silence with underrun
		waitFrames(24);

		if (dut0.chk0.anyFail || |badCmd)
		begin
			$display("Test failed");
			$fatal(1, "checks failed");
		end
		else
		begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

/* tbAudioTx_sva.sv */
`timescale 1ns/1ps
`include "audio_macros.svh"

module tbAudioTx_sva
(
	input logic                            iSCLK,
	input logic                            iSRST,
	input logic [`AUDIO_CH_NUM-1:0]        chanEnable,
	input logic [`AUDIO_CH_NUM-1:0]        chanLoop,
	input logic [`AUDIO_CH_NUM*`IDX_W-1:0] chanStartIdx,
	input logic [`AUDIO_CH_NUM*`IDX_W-1:0] chanEndIdx,
	input logic [`AUDIO_CH_NUM-1:0]        sfmSck,
	input logic [`AUDIO_CH_NUM-1:0]        sfmMosi,
	input logic [`AUDIO_CH_NUM-1:0]        sfmCs,
	input logic [`AUDIO_CH_NUM-1:0]        chanTake,
	input logic [`AUDIO_CH_NUM-1:0]        chanDone,
	input logic                            fifoWe,
	input logic                            fifoEmpty,
	input logic                            fifoRe,
	input logic                            i2sBclk,
	input logic                            i2sLrclk,
	input logic                            i2sSdata,
	input logic                            underrun
);

	localparam int CH = `AUDIO_CH_NUM;

	// Expected read position per channel
	logic [`IDX_W-1:0] expIdx [CH];
	logic [CH-1:0] fin;
	logic [CH-1:0] enQ;
	logic seenEn;
	// Expected mono words in FIFO order
	logic [15:0] expQ [$];
	logic bclkQ;
	logic lrAtRise;
	logic urLast;
	logic urPrev;
	logic [31:0] rxSh;
	logic [31:0] rxWord;
	logic [15:0] rxExp;
	logic rxChk;
	logic rxUr;
	logic rxNone;
	logic failFrame = 1'b0;
	logic failZero = 1'b0;
	logic failReset = 1'b0;
	logic anyFail;

	function automatic logic [15:0] modelSample(int c, logic [15:0] i);
		return 16'(i * 257 + c * 16'h1000);
	endfunction

	// Signed saturation to 16 bits
	function automatic logic [15:0] clampSum(int s);
		if (s > 32767)
			return 16'h7FFF;
		if (s < -32768)
			return 16'h8000;
		return 16'(s);
	endfunction

	// --------------------------------------------------
	// Channel index model and I2S word rebuild
	// --------------------------------------------------
	always @(posedge iSCLK)
	begin : modelSeq
		int sum;
		sum = 0;
		if (iSRST)
		begin
			seenEn   <= 1'b0;
			enQ      <= '0;
			fin      <= '0;
			bclkQ    <= 1'b0;
			lrAtRise <= 1'b0;
			urLast   <= 1'b1;
			urPrev   <= 1'b1;
			rxChk    <= 1'b0;
			expQ.delete();
		end
		else
		begin
			enQ <= chanEnable;
			if (|chanEnable)
				seenEn <= 1'b1;
			for (int c = 0; c < CH; c++)
			begin
				if (chanEnable[c] && !enQ[c])
				begin
					// Fresh enable restarts at the start index
					expIdx[c] <= chanStartIdx[c*`IDX_W +: `IDX_W];
					fin[c]    <= 1'b0;
				end
				else if (chanTake[c] && !fin[c])
				begin
					sum = sum + $signed(modelSample(c, expIdx[c]));
					if (expIdx[c] == chanEndIdx[c*`IDX_W +: `IDX_W])
					begin
						if (chanLoop[c])
							expIdx[c] <= chanStartIdx[c*`IDX_W +: `IDX_W];
						else
							fin[c] <= 1'b1;
					end
					else
						expIdx[c] <= expIdx[c] + 1'b1;
				end
			end
			if (|chanTake)
				expQ.push_back(clampSum(sum));

			bclkQ <= i2sBclk;
			rxChk <= 1'b0;
			// Frame start flags two deep since words complete a frame later
			if (fifoRe || underrun)
			begin
				urPrev <= urLast;
				urLast <= underrun;
			end
			if (i2sBclk && !bclkQ)
			begin
				rxSh     <= {rxSh[30:0], i2sSdata};
				lrAtRise <= i2sLrclk;
				// First rise of the left slot carries the last bit
				if (!i2sLrclk && lrAtRise)
				begin
					rxWord <= {rxSh[30:0], i2sSdata};
					rxChk  <= 1'b1;
					rxUr   <= urPrev;
					rxNone <= !urPrev && (expQ.size() == 0);
					if (!urPrev && expQ.size() != 0)
						rxExp <= expQ.pop_front();
				end
			end
		end
	end

	// --------------------------------------------------
	// Per channel command and done checks
	// --------------------------------------------------
	for (genvar c = 0; c < CH; c++)
	begin : genChk
		logic sckQ;
		logic [5:0] cnt;
		logic [31:0] sh;
		logic cmdChk;
		logic failCmd = 1'b0;
		logic failDone = 1'b0;

		always @(posedge iSCLK)
		begin
			sckQ   <= sfmSck[c];
			cmdChk <= 1'b0;
			if (iSRST || sfmCs[c])
				cnt <= '0;
			else if (sfmSck[c] && !sckQ && cnt < 6'd32)
			begin
				sh     <= {sh[30:0], sfmMosi[c]};
				cnt    <= cnt + 1'b1;
				cmdChk <= (cnt == 6'd31);
			end
		end

		// Opcode then byte address of the start sample
		cmdOk: assert property (@(posedge iSCLK) disable iff (iSRST)
			cmdChk |-> sh[31:24] == `SFM_CMD_READ
			&& sh[23:0] == 24'(chanStartIdx[c*`IDX_W +: `IDX_W] * 2))
		else
		begin
			failCmd = 1'b1;
			$error("CHECK FAILED at %0t: flash read command or address wrong on channel %0d",
				$time, c);
		end

		doneOk: assert property (@(posedge iSCLK) disable iff (iSRST)
			chanDone[c] == $rose(fin[c]))
		else
		begin
			failDone = 1'b1;
			$error("CHECK FAILED at %0t: done pulse mismatch on channel %0d", $time, c);
		end
	end

	frameOk: assert property (@(posedge iSCLK) disable iff (iSRST)
		rxChk && !rxUr |-> !rxNone && rxWord == {rxExp, rxExp})
	else
	begin
		failFrame = 1'b1;
		$error("CHECK FAILED at %0t: I2S frame differs from mixed model samples", $time);
	end

	zeroOk: assert property (@(posedge iSCLK) disable iff (iSRST)
		rxChk && rxUr |-> rxWord == 32'h0)
	else
	begin
		failZero = 1'b1;
		$error("CHECK FAILED at %0t: underrun frame is not silent", $time);
	end

	// Idle outputs until the first enable
	resetOk: assert property (@(posedge iSCLK) disable iff (iSRST)
		!seenEn |-> (&sfmCs) && sfmSck == '0 && sfmMosi == '0 && chanDone == '0
		&& chanTake == '0 && !fifoWe && !fifoRe && fifoEmpty)
	else
	begin
		failReset = 1'b1;
		$error("CHECK FAILED at %0t: outputs not idle before the first enable", $time);
	end

	assign anyFail = failFrame | failZero | failReset
		| genChk[0].failCmd | genChk[1].failCmd | genChk[2].failCmd
		| genChk[0].failDone | genChk[1].failDone | genChk[2].failDone;

endmodule

bind audioTxBlock tbAudioTx_sva chk0 (.*);

/* sfmModel.sv */
`timescale 1ns/1ps
`include "audio_macros.svh"

module sfmModel
#(
	parameter int CH = 0
)
(
	input  logic iSCLK,
	input  logic sck,
	input  logic cs,
	input  logic mosi,
	output logic miso,
	output logic badCmd
);

	logic sckQ;
	logic [5:0] cnt;
	logic [31:0] sh;
	logic [23:0] addr;
	logic [15:0] bitPos;

	initial
	begin
		miso   = 1'b0;
		badCmd = 1'b0;
		sckQ   = 1'b0;
		cnt    = '0;
		bitPos = '0;
	end

	// Content rule, sample i of channel c is i*257 + c*0x1000, big-endian
	function automatic logic [7:0] byteAt(logic [23:0] a);
		logic [15:0] v;
		v = 16'(a[23:1] * 257 + CH * 16'h1000);
		return a[0] ? v[7:0] : v[15:8];
	endfunction

	// --------------------------------------------------
	// Pin decode on the system clock
	// --------------------------------------------------
	always @(posedge iSCLK)
	begin : serve
		logic [23:0] a;
		logic [7:0] b;
		sckQ <= sck;
		if (cs)
		begin
			// Deselected, next command starts fresh
			cnt    <= '0;
			bitPos <= '0;
		end
		else if (sck && !sckQ && cnt < 6'd32)
		begin
			// Command bits latched on SCK rise
			sh  <= {sh[30:0], mosi};
			cnt <= cnt + 1'b1;
			if (cnt == 6'd31)
			begin
				addr <= {sh[22:0], mosi};
				if (sh[30:23] != `SFM_CMD_READ)
					badCmd <= 1'b1;
			end
		end
		else if (!sck && sckQ && cnt == 6'd32)
		begin
			// Next data bit ahead of the SCK rise
			a      = addr + 24'(bitPos >> 3);
			b      = byteAt(a);
			miso   <= b[3'd7 - bitPos[2:0]];
			bitPos <= bitPos + 1'b1;
		end
	end

endmodule

/* audioTxBlock.sv */
`timescale 1ns/1ps
`include "audio_macros.svh"

module audioTxBlock
	import audioPkg::*;
(
	input  logic                            iSCLK,
	input  logic                            iSRST,
	input  logic [`AUDIO_CH_NUM-1:0]        chanEnable,
	input  logic [`AUDIO_CH_NUM-1:0]        chanLoop,
	input  logic [`AUDIO_CH_NUM*`IDX_W-1:0] chanStartIdx,
	input  logic [`AUDIO_CH_NUM*`IDX_W-1:0] chanEndIdx,
	output logic [`AUDIO_CH_NUM-1:0]        sfmSck,
	output logic [`AUDIO_CH_NUM-1:0]        sfmMosi,
	output logic [`AUDIO_CH_NUM-1:0]        sfmCs,
	input  logic [`AUDIO_CH_NUM-1:0]        sfmMiso,
	output logic                            i2sBclk,
	output logic                            i2sLrclk,
	output logic                            i2sSdata,
	output logic [`AUDIO_CH_NUM-1:0]        chanDone,
	output logic                            underrun
);

	// Reader to mixer
	logic [`AUDIO_CH_NUM*`SAMPLE_W-1:0] chanData;
	logic [`AUDIO_CH_NUM-1:0] chanValid;
	logic [`AUDIO_CH_NUM-1:0] chanTake;
	// Mixer to FIFO
	audioFrame_u fifoWd;
	logic fifoWe;
	logic fifoAlmostFull;
	// FIFO to transmitter
	audioFrame_u fifoRd;
	logic fifoEmpty;
	logic fifoRe;

	// --------------------------------------------------
	// One flash reader per channel
	// --------------------------------------------------
	for (genvar c = 0; c < `AUDIO_CH_NUM; c = c + 1)
	begin : genReader
		sfmRomReader reader (
			.iSCLK(iSCLK),
			.iSRST(iSRST),
			.enable(chanEnable[c]),
			.loop(chanLoop[c]),
			.startIdx(chanStartIdx[c*`IDX_W +: `IDX_W]),
			.endIdx(chanEndIdx[c*`IDX_W +: `IDX_W]),
			.sfmSck(sfmSck[c]),
			.sfmMosi(sfmMosi[c]),
			.sfmCs(sfmCs[c]),
			.sfmMiso(sfmMiso[c]),
			.sampleData(chanData[c*`SAMPLE_W +: `SAMPLE_W]),
			.sampleValid(chanValid[c]),
			.sampleTake(chanTake[c]),
			.done(chanDone[c])
		);
	end

	// --------------------------------------------------
	// Mix, buffer, serialize
	// --------------------------------------------------
	pcmMixer mixer0 (
		.iSCLK(iSCLK),
		.iSRST(iSRST),
		.chanEnable(chanEnable),
		.chanValid(chanValid),
		.chanData(chanData),
		.chanTake(chanTake),
		.almostFull(fifoAlmostFull),
		.fifoWd(fifoWd),
		.fifoWe(fifoWe)
	);

	sampleFifo fifo0 (
		.iSCLK(iSCLK),
		.iSRST(iSRST),
		.wd(fifoWd),
		.we(fifoWe),
		.rd(fifoRd),
		.empty(fifoEmpty),
		.almostFull(fifoAlmostFull),
		.re(fifoRe)
	);

	i2sTx i2s0 (
		.iSCLK(iSCLK),
		.iSRST(iSRST),
		.frame(fifoRd),
		.fifoEmpty(fifoEmpty),
		.fifoRe(fifoRe),
		.i2sBclk(i2sBclk),
		.i2sLrclk(i2sLrclk),
		.i2sSdata(i2sSdata),
		.underrun(underrun)
	);

endmodule

/* i2sTx.sv */
`timescale 1ns/1ps
`include "audio_macros.svh"

module i2sTx
	import audioPkg::*;
(
	input  logic        iSCLK,
	input  logic        iSRST,
	input  audioFrame_u frame,
	input  logic        fifoEmpty,
	output logic        fifoRe,
	output logic        i2sBclk,
	output logic        i2sLrclk,
	output logic        i2sSdata,
	output logic        underrun
);

	localparam int FRAME_W = 2 * `SAMPLE_W;
	localparam int BIT_W = $clog2(FRAME_W);
	localparam int DIV_W = $clog2(`I2S_BCLK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`I2S_BCLK_DIV - 1);

	logic [DIV_W-1:0] divCnt;
	// Slot counter, top bit is LRCLK
	logic [BIT_W-1:0] bitCnt;
	logic [BIT_W-1:0] nextBit;
	logic [FRAME_W-1:0] shiftReg;
	logic fallEdge;

	assign fallEdge = (divCnt == DIV_LAST) && i2sBclk;
	assign nextBit  = bitCnt + 1'b1;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			divCnt   <= '0;
			// First falling edge opens slot 0
			bitCnt   <= '1;
			shiftReg <= '0;
			i2sBclk  <= 1'b0;
			i2sLrclk <= 1'b0;
			i2sSdata <= 1'b0;
			fifoRe   <= 1'b0;
			underrun <= 1'b0;
		end
		else
		begin
			fifoRe   <= 1'b0;
			underrun <= 1'b0;

			// --------------------------------------------------
			// BCLK divider
			// --------------------------------------------------
			if (divCnt == DIV_LAST)
			begin
				divCnt  <= '0;
				i2sBclk <= ~i2sBclk;
			end
			else
				divCnt <= divCnt + 1'b1;

			// Everything moves on the BCLK falling edge
			if (fallEdge)
			begin
				bitCnt   <= nextBit;
				i2sLrclk <= nextBit[BIT_W-1];
				// One slot of delay behind LRCLK
				i2sSdata <= shiftReg[FRAME_W-1];
				if (nextBit == '0)
				begin
					// LRCLK edge, fetch next frame; MSB goes out one BCLK later
					shiftReg <= fifoEmpty ? '0 : frame.raw;
					fifoRe   <= !fifoEmpty;
					underrun <= fifoEmpty;
				end
				else
					shiftReg <= {shiftReg[FRAME_W-2:0], 1'b0};
			end
		end
	end

endmodule

/* sampleFifo.sv */
`timescale 1ns/1ps
`include "audio_macros.svh"

module sampleFifo
	import audioPkg::*;
(
	input  logic        iSCLK,
	input  logic        iSRST,
	input  audioFrame_u wd,
	input  logic        we,
	output audioFrame_u rd,
	output logic        empty,
	output logic        almostFull,
	input  logic        re
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;

	audioFrame_u mem [`FIFO_DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] fillCnt;
	logic full;
	logic doWrite;
	logic doRead;

	// --------------------------------------------------
	// Flags from the fill count
	// --------------------------------------------------
	assign full       = (fillCnt == CNT_W'(`FIFO_DEPTH));
	assign empty      = (fillCnt == '0);
	// Mixer holds off here
	assign almostFull = (fillCnt >= CNT_W'(`FIFO_ALERT_LEVEL));

	// Write dropped when full
	assign doWrite = we && !full;
	assign doRead  = re && !empty;

	// Head frame, no read latency
	assign rd = mem[rdPtr];

	always_ff @(posedge iSCLK)
	begin
		if (doWrite)
			mem[wrPtr] <= wd;
	end

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			fillCnt <= '0;
		end
		else
		begin
			// Pointers wrap on power-of-two depth
			if (doWrite)
				wrPtr <= wrPtr + 1'b1;
			if (doRead)
				rdPtr <= rdPtr + 1'b1;
			case ({doWrite, doRead})
				2'b10:   fillCnt <= fillCnt + 1'b1;
				2'b01:   fillCnt <= fillCnt - 1'b1;
				default: fillCnt <= fillCnt;
			endcase
		end
	end

endmodule

/* pcmMixer.sv */
`timescale 1ns/1ps
`include "audio_macros.svh"

module pcmMixer
	import audioPkg::*;
(
	input  logic                               iSCLK,
	input  logic                               iSRST,
	input  logic [`AUDIO_CH_NUM-1:0]           chanEnable,
	input  logic [`AUDIO_CH_NUM-1:0]           chanValid,
	input  logic [`AUDIO_CH_NUM*`SAMPLE_W-1:0] chanData,
	output logic [`AUDIO_CH_NUM-1:0]           chanTake,
	input  logic                               almostFull,
	output audioFrame_u                        fifoWd,
	output logic                               fifoWe
);

	// 18 bits for three channels
	localparam int SUM_W = `SAMPLE_W + $clog2(`AUDIO_CH_NUM);

	logic fire;
	logic signed [SUM_W-1:0] mixSum;
	logic [SUM_W-`SAMPLE_W:0] sumTop;
	logic signed [`SAMPLE_W-1:0] mixSat;

	// --------------------------------------------------
	// Sum of enabled channels
	// --------------------------------------------------
	always_comb
	begin
		mixSum = '0;
		for (int c = 0; c < `AUDIO_CH_NUM; c++)
		begin
			// Disabled channel adds nothing
			if (chanEnable[c])
				mixSum = mixSum + SUM_W'($signed(chanData[c*`SAMPLE_W +: `SAMPLE_W]));
		end
	end

	// Upper bits all equal means it fits
	assign sumTop = mixSum[SUM_W-1:`SAMPLE_W-1];

	always_comb
	begin
		if ((&sumTop) || !(|sumTop))
			mixSat = mixSum[`SAMPLE_W-1:0];
		else if (mixSum[SUM_W-1])
			mixSat = {1'b1, {(`SAMPLE_W-1){1'b0}}};
		else
			mixSat = {1'b0, {(`SAMPLE_W-1){1'b1}}};
	end

	// All enabled valid, room in FIFO, not in the take cycle itself
	assign fire = (|chanEnable) && (&(chanValid | ~chanEnable)) && !almostFull && !fifoWe;

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			chanTake <= '0;
			fifoWe   <= 1'b0;
		end
		else
		begin
			chanTake <= fire ? chanEnable : '0;
			fifoWe   <= fire;
		end
	end

	// Mono mix, left equals right
	always_ff @(posedge iSCLK)
	begin
		if (fire)
		begin
			fifoWd.lr.left  <= mixSat;
			fifoWd.lr.right <= mixSat;
		end
	end

endmodule

/* sfmRomReader.sv */
`timescale 1ns/1ps
`include "audio_macros.svh"

module sfmRomReader
	import audioPkg::*;
(
	input  logic                 iSCLK,
	input  logic                 iSRST,
	input  logic                 enable,
	input  logic                 loop,
	input  logic [`IDX_W-1:0]    startIdx,
	input  logic [`IDX_W-1:0]    endIdx,
	output logic                 sfmSck,
	output logic                 sfmMosi,
	output logic                 sfmCs,
	input  logic                 sfmMiso,
	output logic [`SAMPLE_W-1:0] sampleData,
	output logic                 sampleValid,
	input  logic                 sampleTake,
	output logic                 done
);

	localparam int DIV_W = $clog2(`SFM_SCK_DIV + 1);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SFM_SCK_DIV - 1);
	// Opcode plus 24 address bits
	localparam logic [5:0] CMD_BITS = 6'd32;
	localparam logic [5:0] DATA_BITS = 6'(`SAMPLE_W);

	sfmState_e state;
	logic [DIV_W-1:0] divCnt;
	logic [5:0] bitCnt;
	// Shared by command out and data in
	logic [31:0] shiftReg;
	logic [`IDX_W-1:0] curIdx;
	logic loopPend;
	logic gapCnt;
	logic tick;
	logic startCmd;

	// SCK half period boundary
	assign tick = (divCnt == DIV_LAST);

	// Fresh start, or restart after the CS gap of a loop
	assign startCmd = (state == SFM_IDLE) || ((state == SFM_DONE) && loopPend && gapCnt);

	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			state       <= SFM_IDLE;
			divCnt      <= '0;
			bitCnt      <= '0;
			loopPend    <= 1'b0;
			gapCnt      <= 1'b0;
			sfmCs       <= 1'b1;
			sfmSck      <= 1'b0;
			sfmMosi     <= 1'b0;
			sampleValid <= 1'b0;
			done        <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (!enable)
			begin
				// Abort with CS up next cycle
				state       <= SFM_IDLE;
				divCnt      <= '0;
				sfmCs       <= 1'b1;
				sfmSck      <= 1'b0;
				sfmMosi     <= 1'b0;
				sampleValid <= 1'b0;
			end
			else if (startCmd)
			begin
				// Read opcode then byte address of index * 2
				state    <= SFM_CMD;
				shiftReg <= {`SFM_CMD_READ, 7'd0, startIdx, 1'b0};
				sfmMosi  <= 1'(`SFM_CMD_READ >> 7);
				curIdx   <= startIdx;
				bitCnt   <= '0;
				divCnt   <= '0;
				sfmCs    <= 1'b0;
				sfmSck   <= 1'b0;
			end
			else
			begin
				case (state)
					SFM_CMD, SFM_DATA:
					begin
						divCnt <= tick ? '0 : divCnt + 1'b1;
						if (tick)
						begin
							sfmSck <= ~sfmSck;
							if (!sfmSck)
							begin
								// MISO sampled on the rising edge
								bitCnt <= bitCnt + 1'b1;
								if (state == SFM_DATA)
									shiftReg <= {shiftReg[30:0], sfmMiso};
							end
							else if (state == SFM_CMD)
							begin
								if (bitCnt == CMD_BITS)
								begin
									state   <= SFM_DATA;
									bitCnt  <= '0;
									sfmMosi <= 1'b0;
								end
								else
								begin
									shiftReg <= {shiftReg[30:0], 1'b0};
									sfmMosi  <= shiftReg[30];
								end
							end
							else if (bitCnt == DATA_BITS)
							begin
								// Park with SCK low until taken
								state       <= SFM_HOLD;
								bitCnt      <= '0;
								sampleData  <= shiftReg[`SAMPLE_W-1:0];
								sampleValid <= 1'b1;
							end
						end
					end
					SFM_HOLD:
					begin
						if (sampleTake)
						begin
							sampleValid <= 1'b0;
							if (curIdx == endIdx)
							begin
								state    <= SFM_DONE;
								sfmCs    <= 1'b1;
								loopPend <= loop;
								gapCnt   <= 1'b0;
								done     <= !loop;
							end
							else
							begin
								state  <= SFM_DATA;
								curIdx <= curIdx + 1'b1;
							end
						end
					end
					SFM_DONE:
					begin
						gapCnt <= 1'b1;
						// Finished channel offers silence
						if (!loopPend)
						begin
							sampleData  <= '0;
							sampleValid <= 1'b1;
						end
					end
					default:
						state <= SFM_IDLE;
				endcase
			end
		end
	end

endmodule

/* audioPkg.sv */
`include "audio_macros.svh"

package audioPkg;

	// --------------------------------------------------
	// Stereo frame, left word in the upper half
	// --------------------------------------------------
	typedef struct packed
	{
		logic signed [`SAMPLE_W-1:0] left;
		logic signed [`SAMPLE_W-1:0] right;
	} stereoSample_t;

	// Raw view goes out on I2S MSB first
	typedef union packed
	{
		logic [2*`SAMPLE_W-1:0] raw;
		stereoSample_t lr;
	} audioFrame_u;

	// Flash reader states
	typedef enum logic [2:0]
	{
		SFM_IDLE,
		SFM_CMD,
		SFM_DATA,
		SFM_HOLD,
		SFM_DONE
	} sfmState_e;

endpackage

/* audio_macros.svh */
`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// --------------------------------------------------
// Channel layout
// --------------------------------------------------
// BGM plus two effect channels
`define AUDIO_CH_NUM 3
// PCM sample width
`define SAMPLE_W 16
// Sample index into one flash
`define IDX_W 16

// --------------------------------------------------
// Serial flash and I2S timing
// --------------------------------------------------
`define SFM_CMD_READ 8'h03
// iSCLK cycles per SCK half period
`define SFM_SCK_DIV 2
// iSCLK cycles per BCLK half period
`define I2S_BCLK_DIV 4

// Frame FIFO
`define FIFO_DEPTH 16
`define FIFO_ALERT_LEVEL 12

`endif
